// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FLIST)) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/pc_predictor.sv
hw/imem_axi_reader.sv
hw/if_stage.sv
hw/fetch_top.sv
verif/tb_clock_gen.sv
verif/fetch_props.sv
verif/tb_fetch.sv

// ==== hw/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// fetch front end configuration
////////////////////////////////////////////////////////////////////////////

// address and instruction width, one word
`define FETCH_XLEN 32

// slots per fetch group, tied to the 64-bit line
`define FETCH_WAYS 2

// target buffer depth, must be a power of two
`define FETCH_BTB_ENTRIES 8

// pc loaded on reset
`define FETCH_RESET_PC 32'h0000_0000

// line geometry derived from the two ways above
`define FETCH_LINE_BITS 64
`define FETCH_LINE_BYTES 8

`endif

// ==== hw/fetch_pkg.sv ====
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// fetch group, one slot per instruction word of the line
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                   valid;	// slot holds a real instruction
		logic [`FETCH_XLEN-1:0] pc;	// address of this instruction
		logic [`FETCH_XLEN-1:0] npc;	// where fetch goes after it
		logic [`FETCH_XLEN-1:0] inst;	// raw instruction word
	} fetch_slot_t;

	// slot 0 is the lower word of the line
	typedef fetch_slot_t [`FETCH_WAYS-1:0] fetch_group_t;

	////////////////////////////////////////////////////////////////////////////
	// resolved branch coming back from the back end
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                   valid;	// one-cycle pulse
		logic                   taken;	// taken -> redirect + train
		logic [`FETCH_XLEN-1:0] pc;	// branch address
		logic [`FETCH_XLEN-1:0] target;	// resolved target
	} branch_resolve_t;

	// line returned by the axi reader
	typedef struct packed {
		logic                        valid;
		logic [`FETCH_LINE_BITS-1:0] data;	// low half is the lower address
		logic                        epoch;	// epoch at request time
	} line_resp_t;

	// axi read controller
	typedef enum logic [1:0] {
		IDLE,	// waiting for a request
		ADDR,	// ar channel presented
		DATA	// waiting on r channel
	} reader_state_e;

endpackage

`default_nettype wire

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_top (
	input  logic                         clock,
	input  logic                         reset,
	// axi4-lite read channels to instruction memory
	output logic [`FETCH_XLEN-1:0]       araddr,
	output logic                         arvalid,
	input  logic                         arready,
	output logic [2:0]                   arprot,
	input  logic [`FETCH_LINE_BITS-1:0]  rdata,
	input  logic [1:0]                   rresp,
	input  logic                         rvalid,
	output logic                         rready,
	// pipeline side
	input  fetch_pkg::branch_resolve_t   resolve,
	output fetch_pkg::fetch_group_t      out_group,
	output logic                         out_valid,
	input  logic                         out_ready
);

	logic [`FETCH_XLEN-1:0] fetch_pc;	// shared by predictor and reader
	logic [`FETCH_XLEN-1:0] pred_next_pc;
	logic                   req;
	logic                   req_epoch;
	fetch_pkg::line_resp_t  line_resp;

	////////////////////////////////////////////////////////////////////////////
	// next line prediction
	////////////////////////////////////////////////////////////////////////////

	pc_predictor u_pred (
		.clock        (clock),
		.reset        (reset),
		.fetch_pc     (fetch_pc),
		.resolve      (resolve),
		.pred_next_pc (pred_next_pc)
	);

	// line fetch over axi
	imem_axi_reader u_reader (
		.clock     (clock),
		.reset     (reset),
		.req       (req),
		.req_addr  (fetch_pc),
		.req_epoch (req_epoch),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.arprot    (arprot),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.line_resp (line_resp)
	);

	if_stage u_if (
		.clock        (clock),
		.reset        (reset),
		.pred_next_pc (pred_next_pc),
		.line_resp    (line_resp),
		.resolve      (resolve),
		.fetch_pc     (fetch_pc),
		.req          (req),
		.req_epoch    (req_epoch),
		.out_group    (out_group),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

endmodule

`default_nettype wire

// ==== hw/if_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module if_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [`FETCH_XLEN-1:0]         pred_next_pc,	// from the target buffer
	input  fetch_pkg::line_resp_t          line_resp,	// from the axi reader
	input  fetch_pkg::branch_resolve_t     resolve,	// redirect source
	output logic [`FETCH_XLEN-1:0]         fetch_pc,
	output logic                           req,	// start a line read
	output logic                           req_epoch,
	output fetch_pkg::fetch_group_t        out_group,
	output logic                           out_valid,
	input  logic                           out_ready
);

	logic [`FETCH_XLEN-1:0]      pc_q;
	logic                        epoch_q;	// current fetch epoch
	logic                        fl_epoch_q;	// epoch of the line in flight
	logic                        fl_epoch;
	logic                        inflight_q;
	logic                        inflight_d;
	logic                        req_q;
	logic                        pend_valid_q;	// line parked behind a full output
	logic [`FETCH_LINE_BITS-1:0] pend_line_q;
	logic                        out_valid_q;
	fetch_pkg::fetch_group_t     group_q;
	fetch_pkg::fetch_group_t     group_d;

	logic                        redirect;
	logic                        line_hit;
	logic                        line_stale;
	logic                        out_free;
	logic                        load;
	logic [`FETCH_LINE_BITS-1:0] line_data;

	assign redirect   = resolve.valid && resolve.taken;
	assign line_hit   = line_resp.valid && (line_resp.epoch == epoch_q);
	assign line_stale = line_resp.valid && !line_hit;	// dropped on the floor
	assign out_free   = !out_valid_q || out_ready;
	assign load       = (line_hit || pend_valid_q) && out_free && !redirect;
	assign line_data  = pend_valid_q ? pend_line_q : line_resp.data;

	// request and response never overlap, one read at a time
	assign inflight_d = req_q ? 1'b1 : (line_resp.valid ? 1'b0 : inflight_q);
	assign fl_epoch   = req_q ? epoch_q : fl_epoch_q;

	////////////////////////////////////////////////////////////////////////////
	// split the line into two slots
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		group_d[0].valid = !pc_q[2];	// entry at the upper word skips slot 0
		group_d[0].pc    = {pc_q[`FETCH_XLEN-1:3], 3'b000};
		group_d[0].npc   = {pc_q[`FETCH_XLEN-1:3], 3'b100};	// slot 1 always follows
		group_d[0].inst  = line_data[31:0];
		group_d[1].valid = 1'b1;
		group_d[1].pc    = {pc_q[`FETCH_XLEN-1:3], 3'b100};
		group_d[1].npc   = pred_next_pc;	// last slot takes the prediction
		group_d[1].inst  = line_data[63:32];
	end

	////////////////////////////////////////////////////////////////////////////
	// pc, epoch and request control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q         <= `FETCH_RESET_PC;
			epoch_q      <= 1'b0;
			fl_epoch_q   <= 1'b0;
			inflight_q   <= 1'b0;
			req_q        <= 1'b1;	// first line goes out right after reset
			pend_valid_q <= 1'b0;
			out_valid_q  <= 1'b0;
		end else begin
			inflight_q <= inflight_d;
			if (req_q) fl_epoch_q <= epoch_q;
			if (redirect) begin
				pc_q <= resolve.target;
				// new epoch never equals the one still in flight
				epoch_q      <= inflight_d ? ~fl_epoch : ~epoch_q;
				req_q        <= !inflight_d;	// else wait for the stale line
				pend_valid_q <= 1'b0;
				out_valid_q  <= 1'b0;	// held group is wrong path
			end else begin
				req_q <= load || line_stale;	// next line, or refetch after a kill
				if (load) pc_q <= pred_next_pc;
				if (load) begin
					pend_valid_q <= 1'b0;
				end else if (line_hit) begin
					pend_valid_q <= 1'b1;	// output busy, park it
				end
				if (load) begin
					out_valid_q <= 1'b1;
				end else if (out_ready) begin
					out_valid_q <= 1'b0;
				end
			end
		end
	end

	// payload registers
	always_ff @(posedge clock) begin
		if (line_hit) pend_line_q <= line_resp.data;
		if (load)     group_q     <= group_d;
	end

	assign fetch_pc  = pc_q;
	assign req       = req_q;
	assign req_epoch = epoch_q;
	assign out_group = group_q;
	assign out_valid = out_valid_q;

endmodule

`default_nettype wire

// ==== hw/imem_axi_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module imem_axi_reader (
	input  logic                          clock,
	input  logic                          reset,
	// request from the fetch stage
	input  logic                          req,	// strobe, taken only in IDLE
	input  logic [`FETCH_XLEN-1:0]        req_addr,
	input  logic                          req_epoch,
	// axi4-lite read address channel
	output logic [`FETCH_XLEN-1:0]        araddr,
	output logic                          arvalid,
	input  logic                          arready,
	output logic [2:0]                    arprot,
	// axi4-lite read data channel
	input  logic [`FETCH_LINE_BITS-1:0]   rdata,
	input  logic [1:0]                    rresp,
	input  logic                          rvalid,
	output logic                          rready,
	// line back to the fetch stage
	output fetch_pkg::line_resp_t         line_resp
);

	fetch_pkg::reader_state_e state_q;
	fetch_pkg::reader_state_e state_d;

	logic [`FETCH_XLEN-1:0]      addr_q;	// line aligned
	logic                        epoch_q;	// epoch of the read in flight
	logic                        resp_valid_q;
	logic [`FETCH_LINE_BITS-1:0] resp_data_q;
	logic                        resp_epoch_q;
	logic                        take_req;
	logic                        ar_done;
	logic                        r_done;

	assign take_req = (state_q == fetch_pkg::IDLE) && req;
	assign ar_done  = arvalid && arready;
	assign r_done   = (state_q == fetch_pkg::DATA) && rvalid && rready;

	////////////////////////////////////////////////////////////////////////////
	// controller, one read outstanding
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::IDLE: if (req)     state_d = fetch_pkg::ADDR;
			fetch_pkg::ADDR: if (ar_done) state_d = fetch_pkg::DATA;
			fetch_pkg::DATA: if (r_done)  state_d = fetch_pkg::IDLE;
			default:                      state_d = fetch_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= fetch_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// address and epoch held for the whole transaction
	always_ff @(posedge clock) begin
		if (take_req) begin
			addr_q  <= {req_addr[`FETCH_XLEN-1:3], 3'b000};
			epoch_q <= req_epoch;
		end
	end

	assign araddr  = addr_q;
	assign arvalid = (state_q == fetch_pkg::ADDR);	// stays up until arready
	assign arprot  = 3'b100;	// instruction, secure, unprivileged
	assign rready  = (state_q != fetch_pkg::ADDR);	// high out of reset

	////////////////////////////////////////////////////////////////////////////
	// response register, one cycle after the r handshake
	////////////////////////////////////////////////////////////////////////////

	// a slave error on rresp still hands the line back, error handling is out of scope
	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= r_done;	// single-cycle pulse
		end
	end

	always_ff @(posedge clock) begin
		if (r_done) begin
			resp_data_q  <= rdata;
			resp_epoch_q <= epoch_q;
		end
	end

	assign line_resp = '{valid: resp_valid_q, data: resp_data_q, epoch: resp_epoch_q};

endmodule

`default_nettype wire

// ==== hw/pc_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module pc_predictor (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [`FETCH_XLEN-1:0]         fetch_pc,	// current fetch pc
	input  fetch_pkg::branch_resolve_t     resolve,	// training port
	output logic [`FETCH_XLEN-1:0]         pred_next_pc	// combinational prediction
);

	localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
	localparam int TAG_W = `FETCH_XLEN - 3 - IDX_W;	// bits above index and line offset

	////////////////////////////////////////////////////////////////////////////
	// target buffer storage
	////////////////////////////////////////////////////////////////////////////

	logic [`FETCH_BTB_ENTRIES-1:0] btb_valid;	// only state that is reset
	logic [TAG_W-1:0]              btb_tag    [`FETCH_BTB_ENTRIES];
	logic [`FETCH_XLEN-1:0]        btb_target [`FETCH_BTB_ENTRIES];
	logic                          btb_hi     [`FETCH_BTB_ENTRIES];	// branch in upper word

	logic [IDX_W-1:0]       rd_idx;
	logic [TAG_W-1:0]       rd_tag;
	logic [IDX_W-1:0]       wr_idx;
	logic [TAG_W-1:0]       wr_tag;
	logic                   train;
	logic                   hit;
	logic [`FETCH_XLEN-1:0] seq_pc;

	// lookup side, indexed by line address
	assign rd_idx = fetch_pc[3 +: IDX_W];
	assign rd_tag = fetch_pc[`FETCH_XLEN-1 -: TAG_W];

	// training side uses the branch address
	assign wr_idx = resolve.pc[3 +: IDX_W];
	assign wr_tag = resolve.pc[`FETCH_XLEN-1 -: TAG_W];
	assign train  = resolve.valid && resolve.taken;

	// a branch in slot 0 is skipped when fetch enters at slot 1
	assign hit = btb_valid[rd_idx]
		&& (btb_tag[rd_idx] == rd_tag)
		&& (btb_hi[rd_idx] || !fetch_pc[2]);

	// fall through to the next aligned line
	assign seq_pc = {fetch_pc[`FETCH_XLEN-1:3], 3'b000} + `FETCH_XLEN'(`FETCH_LINE_BYTES);

	assign pred_next_pc = hit ? btb_target[rd_idx] : seq_pc;

	////////////////////////////////////////////////////////////////////////////
	// update, visible one cycle after the resolve pulse
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			btb_valid <= '0;	// forget every prediction
		end else if (train) begin
			btb_valid[wr_idx] <= 1'b1;
		end
	end

	// payload arrays, qualified by btb_valid
	always_ff @(posedge clock) begin
		if (train) begin
			btb_tag[wr_idx]    <= wr_tag;
			btb_target[wr_idx] <= resolve.target;
			btb_hi[wr_idx]     <= resolve.pc[2];	// which word of the line
		end
	end

endmodule

`default_nettype wire

// ==== verif/fetch_props.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_props (
	input logic                       clock,
	input logic                       reset,
	input logic [`FETCH_XLEN-1:0]     araddr,
	input logic                       arvalid,
	input logic                       arready,
	input fetch_pkg::branch_resolve_t resolve,
	input fetch_pkg::fetch_group_t    out_group,
	input logic                       out_valid,
	input logic                       out_ready
);

	// ar channel holds until accepted
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");

	// stalled group never moves
	group_hold: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_group))
		else $error("out_group changed while stalled");

	// only a redirect may drop a stalled valid
	valid_hold: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !(resolve.valid && resolve.taken) |=> out_valid)
		else $error("out_valid dropped while stalled");

endmodule

bind fetch_top fetch_props u_props (.*);

`default_nettype wire

// ==== verif/fetch_vectors.txt ====
# R <branch pc> <target> | W <group count> | E <first valid pc> <slot mask>
# values in hex, mask bit 0 is slot 0
E 0 3
E 8 3
E 10 3
W 3
R 24 104
E 104 2
E 108 3
E 110 3
R 1fc 1c
E 1c 2
E 20 3
E 104 2
E 108 3
W 4

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	initial clock = 1'b0;
	always #4 clock = ~clock;	// 8 ns period

	// reset held for four rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/tb_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch;

	logic                        clock;
	logic                        reset;
	logic [`FETCH_XLEN-1:0]      araddr;
	logic                        arvalid;
	logic                        arready;
	logic [2:0]                  arprot;
	logic [`FETCH_LINE_BITS-1:0] rdata;
	logic [1:0]                  rresp;
	logic                        rvalid;
	logic                        rready;
	fetch_pkg::branch_resolve_t  resolve;
	fetch_pkg::fetch_group_t     out_group;
	logic                        out_valid;
	logic                        out_ready;

	integer seed     = 32'h9683_c712;	// consumer side
	integer mem_seed = 32'h9683_c712 ^ 32'h5a5a_0001;	// memory side, own stream

	byte         rec_kind  [$];
	logic [31:0] rec_a     [$];
	logic [31:0] rec_b     [$];
	logic [31:0] br_pc     [$];	// trained branches, oldest first
	logic [31:0] br_target [$];
	bit          loaded = 0;
	logic [31:0] exp_pc;	// entry pc of the next group

	tb_clock_gen u_clk (.clock(clock), .reset(reset));

	fetch_top dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// vector file, one record per line
	////////////////////////////////////////////////////////////////////////////

	task automatic load_vectors();
		integer fd;
		integer n;
		string  line;
		byte    k;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("verif/fetch_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/fetch_vectors.txt");
			$display("TB FAILED");
			$fatal(1);
		end
		while ($fgets(line, fd) > 0) begin
			b = 0;
			n = $sscanf(line, "%c %h %h", k, a, b);
			if (n >= 2 && k != "#") begin	// skip comments and blanks
				rec_kind.push_back(k);
				rec_a.push_back(a);
				rec_b.push_back(b);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// next line address after a group entered at entry
	function automatic logic [31:0] predict_next(input logic [31:0] entry);
		logic [31:0] nxt;
		nxt = {entry[31:3], 3'b000} + 32'd8;	// untrained line falls through
		foreach (br_pc[j]) begin
			if (br_pc[j][31:3] == entry[31:3]) nxt = br_target[j];	// newest training wins
		end
		return nxt;
	endfunction

	// wait for the next transfer, with random back-pressure
	task automatic next_group(output fetch_pkg::fetch_group_t g);
		bit                      got;
		bit                      held;	// group stalled last cycle
		fetch_pkg::fetch_group_t held_g;
		got    = 0;
		held   = 0;
		held_g = '0;
		while (!got) begin
			@(negedge clock);
			if (held) begin
				assert ({out_valid, out_group} === {1'b1, held_g}) else begin
					$display("ERR stall hold expected %h actual %h",
						{1'b1, held_g}, {out_valid, out_group});
					$display("TB FAILED");
					$fatal(1);
				end
			end
			held   = out_valid && !out_ready;
			held_g = out_group;
			if (out_valid && out_ready) begin	// transfers on the coming edge
				g   = out_group;
				got = 1;
			end
			@(posedge clock);
			out_ready <= ($random(seed) & 3) != 0;
		end
	endtask

	// every group against the line its entry pc selects
	task automatic check_group(input string name, input fetch_pkg::fetch_group_t g,
		input logic [31:0] entry);
		logic [31:0] base;
		logic [31:0] nxt;
		base = {entry[31:3], 3'b000};
		nxt  = predict_next(entry);
		check_val({name, " slot0 valid"}, {31'd0, !entry[2]}, {31'd0, g[0].valid});
		check_val({name, " slot1 valid"}, 32'd1, {31'd0, g[1].valid});
		check_val({name, " slot1 pc"}, base + 32'd4, g[1].pc);
		check_val({name, " slot1 inst"}, ~(base + 32'd4), g[1].inst);
		check_val({name, " slot1 npc"}, nxt, g[1].npc);	// last slot carries the prediction
		if (!entry[2]) begin
			check_val({name, " slot0 pc"}, base, g[0].pc);
			check_val({name, " slot0 inst"}, ~base, g[0].inst);
			check_val({name, " slot0 npc"}, base + 32'd4, g[0].npc);
		end
		exp_pc = nxt;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// vector player
	////////////////////////////////////////////////////////////////////////////

	initial begin
		fetch_pkg::fetch_group_t g;
		string name;
		arready   = 1'b0;
		rdata     = '0;
		rresp     = 2'b00;
		rvalid    = 1'b0;
		resolve   = '0;
		out_ready = 1'b0;
		exp_pc    = `FETCH_RESET_PC;
		load_vectors();
		loaded = 1;
		@(posedge clock);
		while (reset) @(posedge clock);
		for (int i = 0; i < rec_kind.size(); i++) begin
			name = $sformatf("rec%0d", i);
			case (rec_kind[i])
				"R": begin
					out_ready <= 1'b0;	// no transfer on the redirect edge
					resolve   <= '{valid: 1'b1, taken: 1'b1, pc: rec_a[i], target: rec_b[i]};
					@(posedge clock);
					resolve   <= '0;
					br_pc.push_back(rec_a[i]);
					br_target.push_back(rec_b[i]);
					exp_pc = rec_b[i];
				end
				"W": repeat (rec_a[i]) begin
					next_group(g);
					check_group({name, " wait"}, g, exp_pc);
				end
				"E": begin
					next_group(g);
					check_group(name, g, rec_a[i]);
					check_val({name, " pc"}, rec_a[i], g[0].valid ? g[0].pc : g[1].pc);
					check_val({name, " mask"}, rec_b[i], {30'd0, g[1].valid, g[0].valid});
				end
				default: begin
					$display("unknown record kind in vector file at %s", name);
					$display("TB FAILED");
					$fatal(1);
				end
			endcase
		end
		$display("TB PASSED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// axi4-lite memory slave, word = ~address
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] addr;
		int          lat;
		forever begin
			@(negedge clock);
			if (arvalid && arready) begin
				addr = araddr;
				check_val("ar prot instruction", 32'd4, {29'd0, arprot & 3'b100});
				lat  = $unsigned($random(mem_seed)) % 5;
				@(posedge clock);
				arready <= 1'b0;
				repeat (lat) @(posedge clock);
				rdata  <= {~(addr + 32'd4), ~addr};	// low half is the lower word
				rresp  <= 2'b00;
				rvalid <= 1'b1;
				do @(negedge clock); while (!rready);
				@(posedge clock);
				rvalid <= 1'b0;
			end else begin
				@(posedge clock);
				arready <= ($random(mem_seed) & 1) != 0;	// random ar gaps
			end
		end
	end

	// 400 cycles per record
	initial begin
		wait (loaded);
		#(rec_kind.size() * 400 * 8);
		$display("timeout, the fetch front end stopped delivering groups");
		$display("TB FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire
